/* src.f */
+incdir+hw
hw/tlb_pkg.sv
hw/pipe_pkg.sv
hw/tlb_lookup_if.sv
hw/tlb_slot.sv
hw/tlb_hit_select.sv
hw/m1_stage.sv
hw/mem_stage_top.sv
testbench/tb_clk_gen.sv
testbench/mem_stage_chk.sv
testbench/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the m1 stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module mem_stage_tb -Mdir obj_dir -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/mem_stage_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* testbench/mem_stage_tb.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_stage_tb import tlb_pkg::*, pipe_pkg::*; ();

    logic                      clk;
    logic                      reset;
    logic                      es_valid;
    logic [31:0]               es_pc;
    logic [31:0]               es_vaddr;
    logic [1:0]                es_mem_op;
    logic [3:0]                es_wstrb;
    logic [31:0]               es_wdata;
    logic [4:0]                es_dest;
    logic                      ms_allowin;
    logic [`ASID_W-1:0]        asid;
    logic                      dcache_busy;
    logic                      tlb_we;
    logic [`TLB_IDX_W-1:0]     tlb_windex;
    tlb_entry_t                tlb_wentry;
    logic                      m1s_allowin;
    logic                      ms_valid;
    logic [31:0]               ms_pc;
    logic [31:0]               ms_paddr;
    logic [4:0]                ms_dest;
    logic                      ms_ex;
    logic [4:0]                ms_exc_code;
    logic [31:0]               ms_badvaddr;
    logic                      flush;
    logic                      flush_refill;
    logic                      data_valid;
    logic                      data_op;
    logic [`DATA_TAG_W-1:0]    data_tag;
    logic [`DATA_INDEX_W-1:0]  data_index;
    logic [`DATA_OFFSET_W-1:0] data_offset;
    logic [3:0]                data_wstrb;
    logic [31:0]               data_wdata;
    logic                      is_uncache;

    tlb_entry_t  tlb_model [`TLB_ENTRIES];   // what the TLB should hold
    logic [31:0] exp_q [$];                  // pcs accepted, not yet left
    logic [31:0] next_pc;
    logic [31:0] rnd;
    logic        leaving;
    logic        taking;
    integer      seed;
    int          errors;
    int          checks;
    int          test_no;
    int          failed_tests;
    int          err_mark;
    int          sent;
    int          left_cnt;
    int          cyc;
    int          t;
    string       test_name;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    mem_stage_top mem_stage_top_i (.*);

    function automatic int total_errors();
        return errors + mem_stage_top_i.m1_stage_i.chk_i.fail_count;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("error %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = total_errors();
    endtask

    task automatic finish_test();
        test_no++;
        if (total_errors() == err_mark) begin
            $display("test %0d %s ok", test_no, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s failed with %0d errors", test_no, test_name,
                     total_errors() - err_mark);
        end
    endtask

    // cdv packs {c, d, v} of one page
    function automatic tlb_entry_t make_entry(input logic [18:0] vpn2, input logic [7:0] id,
                                              input logic g, input logic [19:0] pfn0,
                                              input logic [4:0] cdv0, input logic [19:0] pfn1,
                                              input logic [4:0] cdv1);
        tlb_entry_t e;
        e.vpn2 = vpn2;
        e.asid = id;
        e.g    = g;
        e.pfn0 = pfn0;
        e.c0   = cdv0[4:2];
        e.d0   = cdv0[1];
        e.v0   = cdv0[0];
        e.pfn1 = pfn1;
        e.c1   = cdv1[4:2];
        e.d1   = cdv1[1];
        e.v1   = cdv1[0];
        return e;
    endfunction

    task automatic write_tlb(input int idx, input tlb_entry_t e);
        tlb_we     = 1'b1;
        tlb_windex = idx[`TLB_IDX_W-1:0];
        tlb_wentry = e;
        @(posedge clk);
        #1;
        tlb_we         = 1'b0;
        tlb_model[idx] = e;
    endtask

    // reference model of one access
    function automatic void predict(input logic [31:0] va, input logic [1:0] op,
                                    input logic [3:0] strb, output logic [4:0] exc,
                                    output logic [31:0] pa, output logic unc,
                                    output logic refill);
        logic        mapped;
        logic        hit;
        logic        bad_align;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        hit = 1'b0;
        pfn = '0;
        c   = '0;
        d   = 1'b0;
        v   = 1'b0;
        for (int k = `TLB_ENTRIES - 1; k >= 0; k--) begin   // lowest slot ends up winning
            if (tlb_model[k].vpn2 == va[31:13]
                    && (tlb_model[k].g || tlb_model[k].asid == asid)) begin
                hit = 1'b1;
                pfn = va[12] ? tlb_model[k].pfn1 : tlb_model[k].pfn0;
                c   = va[12] ? tlb_model[k].c1 : tlb_model[k].c0;
                d   = va[12] ? tlb_model[k].d1 : tlb_model[k].d0;
                v   = va[12] ? tlb_model[k].v1 : tlb_model[k].v0;
            end
        end
        mapped = va[31:30] != 2'b10;
        pa     = mapped ? {pfn, va[11:0]} : {3'b000, va[28:0]};
        unc    = (va[31:29] == 3'b101) || (mapped && c == 3'd2);
        case (strb)
            4'b1111:          bad_align = va[1:0] != 2'b00;
            4'b0011, 4'b1100: bad_align = va[0];
            default:          bad_align = 1'b0;
        endcase
        refill = 1'b0;
        if (op != op_load && op != op_store) begin
            exc = exc_none;
        end else if (bad_align) begin
            exc = exc_ades;
        end else if (mapped && (!hit || !v)) begin
            exc    = (op == op_load) ? exc_tlbl : exc_tlbs;
            refill = !hit;
        end else if (mapped && op == op_store && !d) begin
            exc = exc_mod;
        end else begin
            exc = exc_none;
        end
    endfunction

    task automatic check_access(input logic [31:0] va, input logic [1:0] op,
                                input logic [3:0] strb);
        logic [4:0]  exc;
        logic [31:0] pa;
        logic        unc;
        logic        refill;
        predict(va, op, strb, exc, pa, unc, refill);
        check_val("ms_exc_code", ms_exc_code, exc);
        check_val("ms_ex", ms_ex, exc != exc_none);
        check_val("flush", flush, exc != exc_none);
        check_val("flush_refill", flush_refill, refill);
        check_val("ms_badvaddr", ms_badvaddr, va);
        check_val("data_valid", data_valid, op != op_none && exc == exc_none);
        if (exc == exc_none) begin
            check_val("ms_paddr", ms_paddr, pa);
            check_val("data_tag", data_tag, pa[31:12]);
            check_val("data_index", data_index, pa[11:4]);
            check_val("data_offset", data_offset, pa[3:0]);
            check_val("is_uncache", is_uncache, unc);
            check_val("data_op", data_op, op == op_store);
            check_val("data_wstrb", data_wstrb, (op == op_store) ? strb : 4'b0000);
        end
    endtask

    // one item through the stage with no back-pressure
    task automatic run_access(input logic [31:0] va, input logic [1:0] op,
                              input logic [3:0] strb);
        int n;
        es_valid  = 1'b1;
        es_pc     = next_pc;
        es_vaddr  = va;
        es_mem_op = op;
        es_wstrb  = strb;
        es_wdata  = ~va;
        es_dest   = va[6:2];
        next_pc   = next_pc + 32'd4;
        n = 0;
        @(negedge clk);
        while (!m1s_allowin && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!m1s_allowin)
            report_timeout("m1s_allowin");
        @(posedge clk);
        #1;
        es_valid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!ms_valid && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!ms_valid) begin
            report_timeout("ms_valid");
        end else begin
            check_val("ms_pc", ms_pc, es_pc);
            check_val("ms_dest", ms_dest, va[6:2]);
            check_val("data_wdata", data_wdata, ~va);
            check_access(va, op, strb);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        es_valid     = 1'b0;
        es_pc        = '0;
        es_vaddr     = '0;
        es_mem_op    = op_none;
        es_wstrb     = '0;
        es_wdata     = '0;
        es_dest      = '0;
        ms_allowin   = 1'b1;
        asid         = 8'h05;
        dcache_busy  = 1'b0;
        tlb_we       = 1'b0;
        tlb_windex   = '0;
        tlb_wentry   = '0;
        seed         = 11;
        next_pc      = 32'h0040_0000;
        errors       = 0;
        checks       = 0;
        test_no      = 0;
        failed_tests = 0;

        @(posedge clk);
        #1;
        t = 0;
        while (reset && t < 20) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (reset)
            report_timeout("reset release");

        // invalid filler in every slot, vpn2 unique per slot
        for (int i = 0; i < `TLB_ENTRIES; i++)
            write_tlb(i, make_entry(19'h7ff00 | i, 8'hff, 1'b0, 20'hfff00 | i, 5'b0,
                                    20'hffe00 | i, 5'b0));
        write_tlb(0, make_entry(19'h00010, 8'h05, 1'b0, 20'h12345, {3'd3, 1'b1, 1'b1},
                                20'h6789a, {3'd2, 1'b0, 1'b1}));
        write_tlb(1, make_entry(19'h00020, 8'h05, 1'b0, 20'h0abcd, {3'd3, 1'b1, 1'b0},
                                20'h0bcde, {3'd3, 1'b1, 1'b1}));
        write_tlb(2, make_entry(19'h00030, 8'h07, 1'b0, 20'h55aa5, {3'd3, 1'b1, 1'b1},
                                20'h5aa55, {3'd3, 1'b1, 1'b1}));

        start_test("mapped hit");
        run_access(32'h0002_0124, op_load, 4'b1111);
        run_access(32'h0002_0348, op_store, 4'b1111);
        run_access(32'h0002_1010, op_load, 4'b1111);   // odd page
        finish_test();

        start_test("miss and invalid");
        run_access(32'h0010_0040, op_load, 4'b1111);
        run_access(32'h0010_0044, op_store, 4'b1111);
        run_access(32'h0004_0080, op_load, 4'b1111);   // slot 1 even page, v=0
        run_access(32'h0004_0084, op_store, 4'b1111);
        finish_test();

        start_test("modified and address error");
        run_access(32'h0002_1124, op_store, 4'b1111);
        run_access(32'h0002_0122, op_load, 4'b1111);
        finish_test();

        start_test("asid and global");
        run_access(32'h0006_0010, op_load, 4'b1111);   // asid 7 entry, port asid 5
        write_tlb(2, make_entry(19'h00030, 8'h07, 1'b1, 20'h55aa5, {3'd3, 1'b1, 1'b1},
                                20'h5aa55, {3'd3, 1'b1, 1'b1}));
        run_access(32'h0006_0010, op_load, 4'b1111);
        finish_test();

        start_test("unmapped segments");
        run_access(32'h8123_4568, op_load, 4'b1111);
        run_access(32'hA123_456C, op_store, 4'b1111);
        run_access(32'h0002_1014, op_load, 4'b1111);   // c=2 page
        finish_test();

        start_test("random back-pressure");
        sent     = 0;
        left_cnt = 0;
        cyc      = 0;
        exp_q.delete();
        while (left_cnt < 24 && cyc < 2000) begin
            @(negedge clk);
            leaving = ms_valid && ms_allowin;
            taking  = es_valid && m1s_allowin;
            if (exp_q.size() > 0 && !leaving)
                check_val("m1s_allowin", m1s_allowin, 1'b0);
            if (leaving) begin
                if (exp_q.size() == 0) begin
                    $display("item with pc %h left the stage but none was pending", ms_pc);
                    errors++;
                end else begin
                    check_val("ms_pc", ms_pc, exp_q[0]);
                    void'(exp_q.pop_front());
                    left_cnt++;
                end
            end
            if (taking) begin
                exp_q.push_back(es_pc);
                sent++;
            end
            @(posedge clk);
            #1;
            rnd         = $random(seed);
            dcache_busy = rnd[0];
            ms_allowin  = rnd[1];
            if (taking)
                es_valid = 1'b0;
            if (!es_valid && sent < 24 && rnd[2]) begin
                es_valid  = 1'b1;
                es_pc     = next_pc;
                es_vaddr  = 32'h8000_0000 | (rnd & 32'h1fff_fffc);   // kseg0, aligned
                es_mem_op = rnd[4] ? op_store : (rnd[3] ? op_load : op_none);
                es_wstrb  = 4'b1111;
                es_wdata  = rnd;
                es_dest   = rnd[9:5];
                next_pc   = next_pc + 32'd4;
            end
            cyc++;
        end
        if (left_cnt != 24 || exp_q.size() != 0) begin
            $display("stream stalled, %0d of 24 items left the stage", left_cnt);
            errors++;
        end
        es_valid    = 1'b0;
        dcache_busy = 1'b0;
        ms_allowin  = 1'b1;
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_no, failed_tests, checks, total_errors());
        if (total_errors() == 0 && failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/mem_stage_chk.sv */
`timescale 1ns/100ps

module mem_stage_chk import pipe_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      m1s_valid,
    input logic      ms_valid,
    input logic      ms_allowin,
    input m1_to_ms_t ms_bus,
    input logic      data_valid,
    input logic      flush,
    input logic      flush_refill
);

    int fail_count = 0;   // number of failed assertions

    no_req_on_ex: assert property (@(posedge clk) disable iff (reset)
        data_valid |-> !ms_bus.ex && !flush)
    else begin
        $error("dcache request raised for an item with an exception");
        fail_count++;
    end

    hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
        ms_valid && !ms_allowin |=> m1s_valid && $stable(ms_bus.pc)
            && $stable(ms_bus.vaddr) && $stable(ms_bus.dest) && $stable(ms_bus.mem_op))
    else begin
        $error("stage item changed while the next stage was blocked");
        fail_count++;
    end

    refill_is_flush: assert property (@(posedge clk) disable iff (reset)
        flush_refill |-> flush)
    else begin
        $error("flush_refill raised without flush");
        fail_count++;
    end

endmodule

bind m1_stage mem_stage_chk chk_i (
    .clk          (clk),
    .reset        (reset),
    .m1s_valid    (m1s_valid),
    .ms_valid     (ms_valid),
    .ms_allowin   (ms_allowin),
    .ms_bus       (ms_bus),
    .data_valid   (data_valid),
    .flush        (flush),
    .flush_refill (flush_refill)
);

/* testbench/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* hw/mem_stage_top.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_stage_top import tlb_pkg::*, pipe_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      es_valid,
    input  logic [31:0]               es_pc,
    input  logic [31:0]               es_vaddr,
    input  logic [1:0]                es_mem_op,
    input  logic [3:0]                es_wstrb,
    input  logic [31:0]               es_wdata,
    input  logic [4:0]                es_dest,
    input  logic                      ms_allowin,
    input  logic [`ASID_W-1:0]        asid,
    input  logic                      dcache_busy,
    input  logic                      tlb_we,
    input  logic [`TLB_IDX_W-1:0]     tlb_windex,
    input  tlb_entry_t                tlb_wentry,
    output logic                      m1s_allowin,
    output logic                      ms_valid,
    output logic [31:0]               ms_pc,
    output logic [31:0]               ms_paddr,
    output logic [4:0]                ms_dest,
    output logic                      ms_ex,
    output logic [4:0]                ms_exc_code,
    output logic [31:0]               ms_badvaddr,
    output logic                      flush,
    output logic                      flush_refill,
    output logic                      data_valid,
    output logic                      data_op,
    output logic [`DATA_TAG_W-1:0]    data_tag,
    output logic [`DATA_INDEX_W-1:0]  data_index,
    output logic [`DATA_OFFSET_W-1:0] data_offset,
    output logic [3:0]                data_wstrb,
    output logic [31:0]               data_wdata,
    output logic                      is_uncache
);

    es_to_m1_t es_bus;
    m1_to_ms_t ms_bus;

    tlb_lookup_if tlb_bus ();

    assign es_bus.pc     = es_pc;
    assign es_bus.vaddr  = es_vaddr;
    assign es_bus.mem_op = mem_op_t'(es_mem_op);
    assign es_bus.wstrb  = es_wstrb;
    assign es_bus.wdata  = es_wdata;
    assign es_bus.dest   = es_dest;

    assign ms_pc       = ms_bus.pc;
    assign ms_paddr    = ms_bus.paddr;
    assign ms_dest     = ms_bus.dest;
    assign ms_ex       = ms_bus.ex;
    assign ms_exc_code = ms_bus.exc_code;
    assign ms_badvaddr = ms_bus.vaddr;

    m1_stage m1_stage_i (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .es_bus       (es_bus),
        .m1s_allowin  (m1s_allowin),
        .ms_allowin   (ms_allowin),
        .ms_valid     (ms_valid),
        .ms_bus       (ms_bus),
        .asid         (asid),
        .lookup       (tlb_bus),
        .dcache_busy  (dcache_busy),
        .data_valid   (data_valid),
        .data_op      (data_op),
        .data_tag     (data_tag),
        .data_index   (data_index),
        .data_offset  (data_offset),
        .data_wstrb   (data_wstrb),
        .data_wdata   (data_wdata),
        .is_uncache   (is_uncache),
        .flush        (flush),
        .flush_refill (flush_refill)
    );

    genvar i;
    generate
        for (i = 0; i < `TLB_ENTRIES; i++) begin : g_slot
            tlb_slot #(.SLOT_ID(i)) tlb_slot_i (
                .clk        (clk),
                .reset      (reset),
                .tlb_we     (tlb_we),
                .tlb_windex (tlb_windex),
                .tlb_wentry (tlb_wentry),
                .lookup     (tlb_bus)
            );
        end
    endgenerate

    tlb_hit_select tlb_hit_select_i (
        .lookup (tlb_bus)
    );

endmodule

/* hw/m1_stage.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module m1_stage import tlb_pkg::*, pipe_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     es_valid,
    input  es_to_m1_t                es_bus,
    output logic                     m1s_allowin,
    input  logic                     ms_allowin,
    output logic                     ms_valid,
    output m1_to_ms_t                ms_bus,
    input  logic [`ASID_W-1:0]       asid,
    tlb_lookup_if.stage              lookup,
    input  logic                     dcache_busy,
    output logic                     data_valid,
    output logic                     data_op,
    output logic [`DATA_TAG_W-1:0]   data_tag,
    output logic [`DATA_INDEX_W-1:0] data_index,
    output logic [`DATA_OFFSET_W-1:0] data_offset,
    output logic [3:0]               data_wstrb,
    output logic [31:0]              data_wdata,
    output logic                     is_uncache,
    output logic                     flush,
    output logic                     flush_refill
);

    logic      m1s_valid;
    logic      m1s_ready_go;
    es_to_m1_t bus_r;
    logic      is_load;
    logic      is_store;
    logic      mem_access;
    logic      kseg1;
    logic      unmapped;
    logic      misaligned;
    logic      tlb_miss;
    logic      tlb_invalid;
    logic      tlb_modified;
    logic      m1s_ex;
    exc_code_t exc_code;
    logic [31:0] paddr;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1s_valid <= 1'b0;
        end else if (m1s_allowin) begin
            m1s_valid <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && m1s_allowin) begin
            bus_r <= es_bus;
        end
    end

    assign is_load    = bus_r.mem_op == op_load;
    assign is_store   = bus_r.mem_op == op_store;
    assign mem_access = is_load || is_store;

    // kseg0 100, kseg1 101
    assign kseg1    = bus_r.vaddr[31:29] == 3'b101;
    assign unmapped = bus_r.vaddr[31:30] == 2'b10;

    assign lookup.vpn2 = bus_r.vaddr[31:13];
    assign lookup.asid = asid;
    assign lookup.odd  = bus_r.vaddr[12];

    assign paddr = unmapped ? {3'b000, bus_r.vaddr[28:0]}
                            : {lookup.pfn, bus_r.vaddr[`PAGE_OFS_W-1:0]};

    always_comb begin
        case (bus_r.wstrb)
            4'b1111:          misaligned = |bus_r.vaddr[1:0];  // word
            4'b0011, 4'b1100: misaligned = bus_r.vaddr[0];     // halfword
            default:          misaligned = 1'b0;
        endcase
    end

    assign tlb_miss     = !unmapped && !lookup.found;
    assign tlb_invalid  = !unmapped && lookup.found && !lookup.v;
    assign tlb_modified = !unmapped && lookup.found && lookup.v && is_store && !lookup.d;

    // address error first, then refill/invalid, then modified
    always_comb begin
        if (!mem_access)
            exc_code = exc_none;
        else if (misaligned)
            exc_code = exc_ades;
        else if (tlb_miss || tlb_invalid)
            exc_code = is_load ? exc_tlbl : exc_tlbs;
        else if (tlb_modified)
            exc_code = exc_mod;
        else
            exc_code = exc_none;
    end

    assign m1s_ex = exc_code != exc_none;

    assign m1s_ready_go = m1s_ex || !mem_access || !dcache_busy;
    assign m1s_allowin  = !m1s_valid || (m1s_ready_go && ms_allowin);
    assign ms_valid     = m1s_valid && m1s_ready_go;

    assign flush        = m1s_valid && m1s_ex;
    assign flush_refill = m1s_valid && mem_access && !misaligned && tlb_miss;

    // one request per item, on the leaving edge
    assign data_valid  = m1s_valid && mem_access && !m1s_ex && !dcache_busy && ms_allowin;
    assign data_op     = is_store;
    assign data_tag    = paddr[31:32-`DATA_TAG_W];
    assign data_index  = paddr[`DATA_INDEX_W+`DATA_OFFSET_W-1:`DATA_OFFSET_W];
    assign data_offset = paddr[`DATA_OFFSET_W-1:0];
    assign data_wstrb  = is_store ? bus_r.wstrb : 4'b0000;
    assign data_wdata  = bus_r.wdata;
    assign is_uncache  = kseg1 || (!unmapped && lookup.c == 3'd2);

    assign ms_bus.pc       = bus_r.pc;
    assign ms_bus.vaddr    = bus_r.vaddr;
    assign ms_bus.paddr    = paddr;
    assign ms_bus.mem_op   = bus_r.mem_op;
    assign ms_bus.dest     = bus_r.dest;
    assign ms_bus.ex       = m1s_ex;
    assign ms_bus.exc_code = exc_code;

endmodule

/* hw/tlb_hit_select.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module tlb_hit_select import tlb_pkg::*; (
    tlb_lookup_if.select lookup
);

    tlb_entry_t sel_entry;

    // priority encoder, lowest matching slot wins
    always_comb begin
        lookup.found = 1'b0;
        lookup.index = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (lookup.match[i]) begin
                lookup.found = 1'b1;
                lookup.index = i[`TLB_IDX_W-1:0];
            end
        end
    end

    assign sel_entry = lookup.entries[lookup.index];

    // even/odd page of the pair
    always_comb begin
        if (lookup.odd) begin
            lookup.pfn = sel_entry.pfn1;
            lookup.c   = sel_entry.c1;
            lookup.d   = sel_entry.d1;
            lookup.v   = sel_entry.v1;
        end else begin
            lookup.pfn = sel_entry.pfn0;
            lookup.c   = sel_entry.c0;
            lookup.d   = sel_entry.d0;
            lookup.v   = sel_entry.v0;
        end
    end

endmodule

/* hw/tlb_slot.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module tlb_slot import tlb_pkg::*; #(
    parameter int SLOT_ID = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  tlb_we,
    input  logic [`TLB_IDX_W-1:0] tlb_windex,
    input  tlb_entry_t            tlb_wentry,
    tlb_lookup_if.slot            lookup
);

    localparam logic [`TLB_IDX_W-1:0] slot_idx = SLOT_ID[`TLB_IDX_W-1:0];

    tlb_entry_t entry;
    logic       vpn_hit;
    logic       asid_hit;

    // reset invalidates both pages of the pair
    always_ff @(posedge clk) begin
        if (reset) begin
            entry.v0 <= 1'b0;
            entry.v1 <= 1'b0;
        end else if (tlb_we && tlb_windex == slot_idx) begin
            entry <= tlb_wentry;   // tlbwi style write
        end
    end

    assign vpn_hit  = entry.vpn2 == lookup.vpn2;
    assign asid_hit = entry.g || (entry.asid == lookup.asid);

    // v is checked later by the stage, a match here ignores it
    assign lookup.match[SLOT_ID]   = vpn_hit && asid_hit;
    assign lookup.entries[SLOT_ID] = entry;

endmodule

/* hw/tlb_lookup_if.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

interface tlb_lookup_if import tlb_pkg::*;;

    logic [`VPN2_W-1:0]      vpn2;
    logic [`ASID_W-1:0]      asid;
    logic                    odd;       // vaddr[12], picks the page of the pair
    wire  [`TLB_ENTRIES-1:0] match;     // one bit per slot
    wire  tlb_entry_t        entries [`TLB_ENTRIES];
    logic                    found;
    logic [`TLB_IDX_W-1:0]   index;
    logic [`PFN_W-1:0]       pfn;
    logic [2:0]              c;
    logic                    d;
    logic                    v;

    modport stage  (output vpn2, asid, odd, input found, index, pfn, c, d, v);
    modport slot   (input vpn2, asid, output match, entries);
    modport select (input match, entries, odd, output found, index, pfn, c, d, v);

endinterface

/* hw/pipe_pkg.sv */
`include "mem_defines.svh"

package pipe_pkg;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_t;

    // execute -> m1
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] vaddr;
        mem_op_t     mem_op;
        logic [3:0]  wstrb;    // byte lanes, also gives the access size
        logic [31:0] wdata;
        logic [4:0]  dest;
    } es_to_m1_t;

    // m1 -> next stage
    typedef struct packed {
        logic [31:0]         pc;
        logic [31:0]         vaddr;  // badvaddr on exception
        logic [31:0]         paddr;
        mem_op_t             mem_op;
        logic [4:0]          dest;
        logic                ex;
        tlb_pkg::exc_code_t  exc_code;
    } m1_to_ms_t;

endpackage

/* hw/tlb_pkg.sv */
`include "mem_defines.svh"

package tlb_pkg;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;      // global, asid ignored
        logic [`PFN_W-1:0]  pfn0;   // even page
        logic [2:0]         c0;
        logic               d0;
        logic               v0;
        logic [`PFN_W-1:0]  pfn1;   // odd page
        logic [2:0]         c1;
        logic               d1;
        logic               v1;
    } tlb_entry_t;

    // cause codes as written to Cause.ExcCode
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_ades = 5'd5
    } exc_code_t;

endpackage

/* hw/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// TLB geometry
`define TLB_ENTRIES   16
`define TLB_IDX_W     4

// virtual and physical page fields
`define VPN2_W        19
`define PFN_W         20
`define ASID_W        8
`define PAGE_OFS_W    12

// dcache address split of the physical address
`define DATA_TAG_W    20
`define DATA_INDEX_W  8
`define DATA_OFFSET_W 4

`endif
